// ==== imem_subsys.f ====
source/rv_imem_pkg.sv
source/req_fifo.sv
source/mem_arbiter.sv
source/instruction_memory.sv
source/fetch_resp_unit.sv
source/imem_subsys.sv
verification/imem_subsys_asserts.sv
verification/tb_imem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the imem_subsys testbench with Verilator and run it.
# Exit status is 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_imem_subsys \
  -f imem_subsys.f \
  -o sim_imem_subsys
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/sim_imem_subsys)
run_status=$?
echo "$sim_output"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if echo "$sim_output" | grep -qF "All tests passed!"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== source/fetch_resp_unit.sv ====
//####################################################################
// Fetch response unit
// Credit-limited reads in flight and an in-order response buffer
//####################################################################
`timescale 1ns/1ps

module fetch_resp_unit (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_issue,      // Read granted this cycle
  input  logic        rdata_valid,      // Read word returning from memory
  input  logic [31:0] rdata,
  output logic        fetch_credit_ok,  // Another read may be issued
  output logic        resp_valid,
  input  logic        resp_ready,
  output logic [31:0] resp_data
);

  import rv_imem_pkg::*;

  logic [31:0]            buf_q [FETCH_DEPTH];  // Returned words waiting for the core
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [FETCH_CNT_W-1:0] in_flight;            // Issued, not yet back from memory
  logic [FETCH_CNT_W-1:0] buf_cnt;              // Words held in the buffer
  logic [FETCH_CNT_W:0]   occupancy;
  logic                   pop;

  // Every issued read already owns a buffer slot, so nothing overflows
  assign occupancy       = in_flight + buf_cnt;
  assign fetch_credit_ok = (occupancy < (FETCH_CNT_W + 1)'(FETCH_DEPTH));

  assign resp_valid = (buf_cnt != '0);
  assign resp_data  = buf_q[rd_ptr];  // Oldest word first
  assign pop        = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (rdata_valid) begin
      buf_q[wr_ptr] <= rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      in_flight <= '0;
      buf_cnt   <= '0;
    end else begin
      if (rdata_valid) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Reads move from in flight to buffered
      case ({fetch_issue, rdata_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
      case ({rdata_valid, pop})
        2'b10:   buf_cnt <= buf_cnt + 1'b1;
        2'b01:   buf_cnt <= buf_cnt - 1'b1;
        default: buf_cnt <= buf_cnt;  // Fill and drain in the same cycle
      endcase
    end
  end

endmodule

// ==== source/imem_subsys.sv ====
//####################################################################
// Instruction memory subsystem top
// Fetch and store queues sharing one program memory via an arbiter
//####################################################################
`timescale 1ns/1ps

module imem_subsys (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_req_valid,
  output logic                    fetch_req_ready,
  input  rv_imem_pkg::fetch_req_t fetch_req,
  output logic                    fetch_resp_valid,
  input  logic                    fetch_resp_ready,
  output logic [31:0]             fetch_resp_data,
  input  logic                    store_req_valid,
  output logic                    store_req_ready,
  input  rv_imem_pkg::store_req_t store_req,
  output logic                    stores_drained  // FENCE.I may refetch
);

  import rv_imem_pkg::*;

  // Queue heads toward the arbiter
  logic        fq_valid;
  logic        fq_ready;
  fetch_req_t  fq_data;
  logic        sq_valid;
  logic        sq_ready;
  store_req_t  sq_data;

  // Memory port and response side
  logic        fetch_credit_ok;
  logic        fetch_issue;
  logic        cmd_valid;
  mem_cmd_t    cmd;
  logic        rdata_valid;
  logic [31:0] rdata;

  req_fifo #(.payload_t(fetch_req_t)) u_fetch_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (fetch_req_valid),
    .in_ready  (fetch_req_ready),
    .in_data   (fetch_req),
    .out_valid (fq_valid),
    .out_ready (fq_ready),
    .out_data  (fq_data),
    .empty     ()
  );

  // Empty store queue means every accepted store is in memory
  req_fifo #(.payload_t(store_req_t)) u_store_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (store_req_valid),
    .in_ready  (store_req_ready),
    .in_data   (store_req),
    .out_valid (sq_valid),
    .out_ready (sq_ready),
    .out_data  (sq_data),
    .empty     (stores_drained)
  );

  mem_arbiter u_arb (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_valid     (fq_valid),
    .fetch_ready     (fq_ready),
    .fetch_in        (fq_data),
    .fetch_credit_ok (fetch_credit_ok),
    .store_valid     (sq_valid),
    .store_ready     (sq_ready),
    .store_in        (sq_data),
    .cmd_valid       (cmd_valid),
    .cmd             (cmd),
    .fetch_issue     (fetch_issue)
  );

  instruction_memory u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .rdata_valid (rdata_valid),
    .rdata       (rdata)
  );

  fetch_resp_unit u_resp (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_issue     (fetch_issue),
    .rdata_valid     (rdata_valid),
    .rdata           (rdata),
    .fetch_credit_ok (fetch_credit_ok),
    .resp_valid      (fetch_resp_valid),
    .resp_ready      (fetch_resp_ready),
    .resp_data       (fetch_resp_data)
  );

endmodule

// ==== source/instruction_memory.sv ====
//####################################################################
// Program memory array
// Byte array with registered word reads and SB/SH/SW writes
//####################################################################
`timescale 1ns/1ps

module instruction_memory (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  rv_imem_pkg::mem_cmd_t cmd,
  output logic                  rdata_valid,  // Read word ready, one cycle after grant
  output logic [31:0]           rdata
);

  import rv_imem_pkg::*;

  logic [7:0]        mem [MEM_SIZE];  // Little-endian byte storage
  logic [ADDR_W-3:0] word_idx;        // Word index, address aligned down
  logic [ADDR_W-1:0] half_hi_addr;    // Second byte of a halfword store
  logic              do_read;
  logic              do_write;

  assign word_idx     = cmd.addr[ADDR_W-1:2];
  assign half_hi_addr = cmd.addr + ADDR_W'(1);  // Wraps at the top of memory
  assign do_read      = cmd_valid && !cmd.we;
  assign do_write     = cmd_valid && cmd.we;

  // Power-up content is all NOPs
  initial begin
    for (int i = 0; i < MEM_SIZE; i += 4) begin
      mem[i]     = NOP_WORD[7:0];
      mem[i + 1] = NOP_WORD[15:8];
      mem[i + 2] = NOP_WORD[23:16];
      mem[i + 3] = NOP_WORD[31:24];
    end
  end

  // Store path, bytes change at the edge of the grant
  always @(posedge clk) begin
    if (do_write) begin
      case (cmd.width)
        SB: begin
          mem[cmd.addr] <= cmd.data[7:0];
        end
        SH: begin
          mem[cmd.addr]     <= cmd.data[7:0];
          mem[half_hi_addr] <= cmd.data[15:8];
        end
        SW: begin
          mem[{word_idx, 2'd0}] <= cmd.data[7:0];
          mem[{word_idx, 2'd1}] <= cmd.data[15:8];
          mem[{word_idx, 2'd2}] <= cmd.data[23:16];
          mem[{word_idx, 2'd3}] <= cmd.data[31:24];
        end
        default: ;  // SD and unused funct3 codes leave memory alone
      endcase
    end
  end

  // Word assembled from four bytes, lowest address in the low byte
  always_ff @(posedge clk) begin
    if (do_read) begin
      rdata <= {mem[{word_idx, 2'd3}], mem[{word_idx, 2'd2}],
                mem[{word_idx, 2'd1}], mem[{word_idx, 2'd0}]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= do_read;  // Single-cycle pulse per read
    end
  end

endmodule

// ==== source/mem_arbiter.sv ====
//####################################################################
// Memory port arbiter
// Round-robin between fetch reads and store writes, one per cycle
//####################################################################
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_valid,
  output logic                   fetch_ready,
  input  rv_imem_pkg::fetch_req_t fetch_in,
  input  logic                   fetch_credit_ok,  // Room for one more read result
  input  logic                   store_valid,
  output logic                   store_ready,
  input  rv_imem_pkg::store_req_t store_in,
  output logic                   cmd_valid,
  output rv_imem_pkg::mem_cmd_t  cmd,
  output logic                   fetch_issue       // One read launched this cycle
);

  import rv_imem_pkg::*;

  logic fetch_elig;
  logic grant_fetch;
  logic grant_store;
  logic last_store;  // Winner of the previous grant, 1 = store

  // Fetch competes only while the response side has a free slot
  assign fetch_elig  = fetch_valid && fetch_credit_ok;
  // On a tie the side that lost last time wins
  assign grant_fetch = fetch_elig && (!store_valid || last_store);
  assign grant_store = store_valid && !grant_fetch;

  assign fetch_ready = grant_fetch;
  assign store_ready = grant_store;
  assign fetch_issue = grant_fetch;
  assign cmd_valid   = grant_fetch || grant_store;

  // Command built from whichever payload won
  always_comb begin
    if (grant_store) begin
      cmd.we    = 1'b1;
      cmd.addr  = store_in.addr;
      cmd.data  = store_in.data;
      cmd.width = store_in.width;  // Odd codes passed on, memory drops them
    end else begin
      cmd.we    = 1'b0;            // Read of the fetch address
      cmd.addr  = fetch_in.addr;
      cmd.data  = 32'h0;
      cmd.width = SW;
    end
  end

  // Starts as if store had won, so fetch goes first after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_store <= 1'b1;
    end else if (cmd_valid) begin
      last_store <= grant_store;
    end
  end

endmodule

// ==== source/req_fifo.sv ====
//####################################################################
// Request queue
// Two-entry valid/ready FIFO for any packed request payload
//####################################################################
`timescale 1ns/1ps

module req_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,   // Producer side
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,  // Head toward the arbiter
  input  logic     out_ready,
  output payload_t out_data,
  output logic     empty
);

  payload_t   entry_q [2];  // Storage, indexed by the pointers
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;        // 0, 1 or 2 entries held
  logic       push;
  logic       pop;

  // Head is only visible from the cycle after it was written
  assign out_valid = (count != 2'd0);
  assign out_data  = entry_q[rd_ptr];
  assign empty     = (count == 2'd0);

  assign pop  = out_valid && out_ready;
  // Full queue still takes a request when the head leaves this cycle
  assign in_ready = (count != 2'd2) || pop;
  assign push     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      entry_q[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;  // Two entries, pointer just toggles
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

endmodule

// ==== source/rv_imem_pkg.sv ====
//####################################################################
// RV32 instruction memory subsystem definitions
// Memory geometry, store width codes and request/command structs
//####################################################################
package rv_imem_pkg;

  // Memory geometry
  localparam int MEM_SIZE = 4096;  // Program memory in bytes
  localparam int ADDR_W   = 12;    // Byte address bits

  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  // Fetch pipeline limits
  localparam int FETCH_DEPTH = 2;                        // In flight plus buffered
  localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);  // Counter for 0..FETCH_DEPTH

  // Store width, taken from funct3 of the store instruction
  typedef enum logic [2:0] {
    SB = 3'b000,  // Byte
    SH = 3'b001,  // Halfword, byte address as given
    SW = 3'b010   // Word, aligned down
  } store_width_e;

  // Fetch request from the core
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // Byte address, low bits ignored
  } fetch_req_t;

  // Store request hitting program memory
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // Byte address
    logic [31:0]       data;   // Store data, low bytes used for SB/SH
    store_width_e      width;  // funct3 code
  } store_req_t;

  // Arbitrated command toward the memory array
  typedef struct packed {
    logic              we;     // 1 = store, 0 = fetch read
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    store_width_e      width;  // Only meaningful with we
  } mem_cmd_t;

endpackage

// ==== verification/imem_subsys_asserts.sv ====
//####################################################################
// Arbiter checks bound into mem_arbiter
// One grant per command, credit-gated fetches, stable waiting requests
//####################################################################
`timescale 1ns/1ps

module imem_subsys_asserts (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    fetch_valid,
  input logic                    fetch_ready,
  input rv_imem_pkg::fetch_req_t fetch_in,
  input logic                    fetch_credit_ok,
  input logic                    store_valid,
  input logic                    store_ready,
  input rv_imem_pkg::store_req_t store_in,
  input logic                    cmd_valid
);

  // A memory command belongs to exactly one requester
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid |-> (fetch_ready != store_ready))
    else $error("Arbiter granted both or neither requester with cmd_valid high");

  // Response buffer must have room before a read goes out
  a_fetch_credit: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_ready |-> fetch_credit_ok)
    else $error("Fetch granted while the response unit had no credit");

  // Queue heads wait with the same payload until granted
  a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_valid && !fetch_ready) |=> (fetch_valid && $stable(fetch_in)))
    else $error("Waiting fetch request dropped or changed its address");

  a_store_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (store_valid && !store_ready) |=> (store_valid && $stable(store_in)))
    else $error("Waiting store request dropped or changed its payload");

endmodule

// ==== verification/tb_imem_subsys.sv ====
//####################################################################
// Testbench for the instruction memory subsystem
// Seeded random fetch/store traffic checked against a byte-array model
//####################################################################
`timescale 1ns/1ps

module tb_imem_subsys;

  import rv_imem_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 4;
  localparam int N_POWERUP  = 20;
  localparam int N_WORD_ST  = 30;  // Each one refetched later
  localparam int N_SUBW_ST  = 24;  // Each one refetched later
  localparam int N_MIX_F    = 40;
  localparam int N_MIX_S    = 40;
  localparam int N_STALL_F  = 40;
  localparam int TOTAL_TXN  = N_POWERUP + 2 * N_WORD_ST + 2 * N_SUBW_ST
                              + N_MIX_F + N_MIX_S + N_STALL_F;
  localparam int CYCLES_PER_TXN = 40;

  logic        clk;
  logic        rst_n;
  logic        fetch_req_valid;
  logic        fetch_req_ready;
  fetch_req_t  fetch_req;
  logic        fetch_resp_valid;
  logic        fetch_resp_ready;
  logic [31:0] fetch_resp_data;
  logic        store_req_valid;
  logic        store_req_ready;
  store_req_t  store_req;
  logic        stores_drained;

  logic [7:0]  model_mem [MEM_SIZE];  // Reference copy of program memory
  logic [31:0] exp_q [$];             // Expected words in request order
  fetch_req_t  fetch_todo [$];
  store_req_t  store_todo [$];
  store_req_t  store_log [$];         // Stores to refetch after the fence
  string       test_name;
  int          errors;
  int          resp_checked;
  int          fetch_pct;             // Chance per cycle to raise a valid
  int          store_pct;
  bit          stall_mode;            // Random back-pressure on the response
  int          stall_left;
  bit          saw_req_stall;

  imem_subsys i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_req_valid  (fetch_req_valid),
    .fetch_req_ready  (fetch_req_ready),
    .fetch_req        (fetch_req),
    .fetch_resp_valid (fetch_resp_valid),
    .fetch_resp_ready (fetch_resp_ready),
    .fetch_resp_data  (fetch_resp_data),
    .store_req_valid  (store_req_valid),
    .store_req_ready  (store_req_ready),
    .store_req        (store_req),
    .stores_drained   (stores_drained)
  );

  bind mem_arbiter imem_subsys_asserts u_arb_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_valid     (fetch_valid),
    .fetch_ready     (fetch_ready),
    .fetch_in        (fetch_in),
    .fetch_credit_ok (fetch_credit_ok),
    .store_valid     (store_valid),
    .store_ready     (store_ready),
    .store_in        (store_in),
    .cmd_valid       (cmd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Little-endian word read of the model, address aligned down
  function automatic logic [31:0] model_word(logic [ADDR_W-1:0] addr);
    int base;
    base = int'(addr) - (int'(addr) % 4);
    return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
  endfunction

  function automatic void model_store(store_req_t s);
    int a;
    a = int'(s.addr);
    case (s.width)
      SB: model_mem[a] = s.data[7:0];
      SH: begin
        model_mem[a]                  = s.data[7:0];
        model_mem[(a + 1) % MEM_SIZE] = s.data[15:8];  // Top byte wraps to 0
      end
      SW: begin
        a = a - (a % 4);
        for (int i = 0; i < 4; i++) begin
          model_mem[a + i] = s.data[8*i +: 8];
        end
      end
      default: ;  // funct3 011 and up change nothing
    endcase
  endfunction

  function automatic fetch_req_t random_fetch(int base, int span);
    fetch_req_t f;
    f.addr = ADDR_W'(base + 4 * int'($urandom_range(span / 4 - 1)));
    return f;
  endfunction

  function automatic store_req_t random_store(int base, int span, bit any_width);
    store_req_t s;
    int         pick;
    s.addr = ADDR_W'(base + int'($urandom_range(span - 1)));
    s.data = $urandom();
    pick   = int'($urandom_range(99));
    if (!any_width || (pick >= 70 && pick < 85)) begin
      s.width = SW;
    end else if (pick < 35) begin
      s.width = SB;
    end else if (pick < 70) begin
      s.width = SH;
    end else begin
      s.width = store_width_e'(3'($urandom_range(7, 3)));  // SD and unused codes
    end
    return s;
  endfunction

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch: [%s] %s expected %0b actual %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_response(logic [31:0] data);
    logic [31:0] exp;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Error: [%s] response 0x%08h came with no fetch outstanding",
               test_name, data);
    end else begin
      exp = exp_q.pop_front();
      resp_checked++;
      if (data !== exp) begin
        errors++;
        $display("Mismatch: [%s] expected 0x%08h actual 0x%08h", test_name, exp, data);
      end
    end
  endtask

  // Hold a raised valid until its transfer, else maybe offer the next one
  task automatic drive_inputs(bit fetch_fire, bit store_fire);
    if (!(fetch_req_valid && !fetch_fire)) begin
      fetch_req_valid = (fetch_todo.size() > 0) && ($urandom_range(99) < fetch_pct);
      fetch_req       = fetch_req_valid ? fetch_todo[0] : '0;
    end
    if (!(store_req_valid && !store_fire)) begin
      store_req_valid = (store_todo.size() > 0) && ($urandom_range(99) < store_pct);
      store_req       = store_req_valid ? store_todo[0] : '0;
    end
    if (stall_mode) begin
      if (stall_left == 0) begin
        fetch_resp_ready = ~fetch_resp_ready;
        stall_left = fetch_resp_ready ? int'($urandom_range(6, 1))
                                      : int'($urandom_range(16, 6));
      end
      stall_left--;
    end
  endtask

  // Sample handshakes mid-cycle, drive just after the rising edge
  task automatic step_cycle();
    bit fetch_fire;
    bit store_fire;
    @(negedge clk);
    fetch_fire = fetch_req_valid && fetch_req_ready;
    store_fire = store_req_valid && store_req_ready;
    if (store_fire) begin
      model_store(store_req);
      void'(store_todo.pop_front());
    end
    if (fetch_fire) begin
      exp_q.push_back(model_word(fetch_req.addr));
      void'(fetch_todo.pop_front());
    end
    if (fetch_resp_valid && fetch_resp_ready) begin
      check_response(fetch_resp_data);
    end
    if (fetch_req_valid && !fetch_req_ready && !fetch_resp_ready) begin
      saw_req_stall = 1'b1;  // Queue backed up behind the stalled output
    end
    @(posedge clk);
    #2;
    drive_inputs(fetch_fire, store_fire);
  endtask

  task automatic run_traffic();
    while (fetch_todo.size() > 0 || store_todo.size() > 0 || fetch_req_valid
           || store_req_valid || exp_q.size() > 0) begin
      step_cycle();
    end
  endtask

  task automatic fence_and_refetch();
    while (!stores_drained) begin
      step_cycle();  // FENCE.I waits here
    end
    foreach (store_log[i]) begin
      fetch_todo.push_back('{addr: {store_log[i].addr[ADDR_W-1:2], 2'b00}});
    end
    store_log.delete();
    run_traffic();
  endtask

  initial begin
    fetch_req_valid  = 1'b0;
    fetch_req        = '0;
    fetch_resp_ready = 1'b1;
    store_req_valid  = 1'b0;
    store_req        = '0;
    rst_n            = 1'b0;
    errors           = 0;
    resp_checked     = 0;
    stall_mode       = 1'b0;
    stall_left       = 0;
    saw_req_stall    = 1'b0;
    void'($urandom(77));
    for (int i = 0; i < MEM_SIZE; i += 4) begin
      {model_mem[i + 3], model_mem[i + 2], model_mem[i + 1], model_mem[i]} = NOP_WORD;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;

    test_name = "powerup";
    @(negedge clk);
    check_flag("stores_drained", 1'b1, stores_drained);
    check_flag("fetch_resp_valid", 1'b0, fetch_resp_valid);
    check_flag("fetch_req_ready", 1'b1, fetch_req_ready);
    check_flag("store_req_ready", 1'b1, store_req_ready);
    @(posedge clk);
    #2;
    fetch_pct = 70;
    store_pct = 0;
    repeat (N_POWERUP) fetch_todo.push_back(random_fetch(0, MEM_SIZE));
    run_traffic();

    test_name = "word_stores";
    store_pct = 80;
    repeat (N_WORD_ST) store_log.push_back(random_store(0, MEM_SIZE, 1'b0));
    store_todo = store_log;
    run_traffic();
    fence_and_refetch();

    test_name = "subword_stores";
    repeat (N_SUBW_ST) store_log.push_back(random_store(0, MEM_SIZE, 1'b1));
    store_todo = store_log;
    run_traffic();
    fence_and_refetch();

    // Stores high, fetches low, so model order within a cycle does not matter
    test_name = "concurrent";
    fetch_pct = 50;
    store_pct = 50;
    repeat (N_MIX_S) store_todo.push_back(random_store(MEM_SIZE / 2, MEM_SIZE / 2 - 1, 1'b1));
    repeat (N_MIX_F) fetch_todo.push_back(random_fetch(0, MEM_SIZE / 2));
    run_traffic();
    while (!stores_drained) step_cycle();

    test_name = "backpressure";
    fetch_pct        = 100;
    stall_mode       = 1'b1;
    stall_left       = 12;  // Opening stall long enough to fill the queue
    fetch_resp_ready = 1'b0;
    repeat (N_STALL_F) fetch_todo.push_back(random_fetch(0, MEM_SIZE));
    run_traffic();
    stall_mode       = 1'b0;
    fetch_resp_ready = 1'b1;
    if (!saw_req_stall) begin
      errors++;
      $display("Error: [%s] fetch_req_ready never dropped while the output stalled",
               test_name);
    end

    $display("Checked %0d responses, %0d errors", resp_checked, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget of cycles per planned transaction covers every test
  initial begin
    repeat (TOTAL_TXN * CYCLES_PER_TXN + RST_CYCLES) @(posedge clk);
    $display("Error: watchdog expired in %s, traffic did not complete", test_name);
    $display("Test failures found");
    $finish;
  end

endmodule
